/* common/fpm_pkg.sv */
package fpm_pkg;

	// widths fixed by the instruction format
	localparam int exp_w = 8;
	localparam int exp_ext_w = 10;
	localparam int ir_w = 3;
	localparam int fic_w = 6;

	// legal signed exponent range
	localparam int exp_max = 127;
	localparam int exp_min = -128;

	typedef logic [exp_w-1:0] exp_t;
	typedef logic [exp_ext_w-1:0] exp_ext_t;
	typedef logic [fic_w-1:0] fic_t;
	typedef logic [ir_w-1:0] ir_field_t;

	// decoded arithmetic operation, op_none when not an fp instruction
	typedef enum logic [3:0] {
		op_none = 4'd0,
		op_ad   = 4'd1,
		op_sd   = 4'd2,
		op_mw   = 4'd3,
		op_dw   = 4'd4,
		op_af   = 4'd5,
		op_sf   = 4'd6,
		op_mf   = 4'd7,
		op_df   = 4'd8
	} fp_op_t;

	// B bus source
	typedef enum logic [1:0] {
		bsel_inv  = 2'd0,
		bsel_pass = 2'd1,
		bsel_ones = 2'd2,
		bsel_zero = 2'd3
	} b_sel_t;

	typedef struct packed {
		logic ad_sd;
		logic mw_mf;
		logic dw_df;
		logic af_sf;
		logic is_float;
		logic is_fixed;
	} op_flags_t;

	// mantissa status from the T/M/C side
	typedef struct packed {
		logic t_zero;
		logic t_sign;
		logic t_ovf;
		logic carry;
	} t_status_t;

	typedef struct packed {
		logic c_f;
		logic v_f;
		logic m_f;
		logic z_f;
	} cond_flags_t;

endpackage

/* rtl/fpm_decoder.sv */
module fpm_decoder import fpm_pkg::*; (
	input  logic      f2strob,
	input  logic      _0_d_,
	input  logic      start,
	input  ir_field_t ir,
	input  logic      pufa,
	output fp_op_t    op,
	output op_flags_t op_flags
);

	fp_op_t op_next;

	// instruction field order: ad sd mw dw af sf mf df
	always_comb begin
		op_next = op_none;
		if (pufa) begin
			case (ir)
				3'd0: op_next = op_ad;
				3'd1: op_next = op_sd;
				3'd2: op_next = op_mw;
				3'd3: op_next = op_dw;
				3'd4: op_next = op_af;
				3'd5: op_next = op_sf;
				3'd6: op_next = op_mf;
				default: op_next = op_df;
			endcase
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			op <= op_none;
		end else if (start) begin
			op <= op_next;
		end
	end

	// operation groups
	always_comb begin
		op_flags = '0;
		op_flags.ad_sd = (op == op_ad) || (op == op_sd);
		op_flags.mw_mf = (op == op_mw) || (op == op_mf);
		op_flags.dw_df = (op == op_dw) || (op == op_df);
		op_flags.af_sf = (op == op_af) || (op == op_sf);
		case (op)
			op_af, op_sf, op_mf, op_df: op_flags.is_float = 1'b1;
			op_ad, op_sd, op_mw, op_dw: op_flags.is_fixed = 1'b1;
			default: begin
				op_flags.is_float = 1'b0;
				op_flags.is_fixed = 1'b0;
			end
		endcase
	end

endmodule

/* exponent/fpm_exp_path.sv */
module fpm_exp_path import fpm_pkg::*; (
	input  logic     f2strob,
	input  logic     _0_d_,
	input  logic     ld,
	input  logic     lkb,
	input  exp_t     w,
	input  logic     b_ld,
	input  b_sel_t   b_sel,
	input  logic     pc8,
	input  logic     align,
	output exp_t     d,
	output exp_ext_t sum,
	output logic     sum_neg,
	output logic     exp_range
);

	exp_ext_t l_bus;
	exp_ext_t d_reg;
	exp_t     b_reg;
	exp_t     b_bus;
	exp_ext_t b_ext;
	exp_ext_t d_ext;
	exp_ext_t carry_in;
	logic     above_max;
	logic     below_min;

	// L bus, w with the two extension bits or the adder result
	always_comb begin
		if (lkb) begin
			l_bus = {{(exp_ext_w-exp_w){w[exp_w-1]}}, w};
		end else begin
			l_bus = sum;
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			d_reg <= '0;
		end else if (ld) begin
			d_reg <= l_bus;
		end
	end

	assign d = d_reg[exp_w-1:0];

	// B takes the old D when ld and b_ld coincide
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			b_reg <= '0;
		end else if (b_ld) begin
			b_reg <= d_reg[exp_w-1:0];
		end
	end

	always_comb begin
		case (b_sel)
			bsel_inv:  b_bus = ~b_reg;
			bsel_pass: b_bus = b_reg;
			bsel_ones: b_bus = '1;
			default:   b_bus = '0;
		endcase
	end

	// exponent adder, both operands sign extended
	assign b_ext = {{(exp_ext_w-exp_w){b_bus[exp_w-1]}}, b_bus};
	assign d_ext = {{(exp_ext_w-exp_w){d[exp_w-1]}}, d};
	assign carry_in = exp_ext_t'(pc8);
	assign sum = b_ext + d_ext + carry_in;
	assign sum_neg = sum[exp_ext_w-1];

	assign above_max = $signed(sum) > exp_max;
	assign below_min = $signed(sum) < exp_min;

	// out of range, sampled when the counter is loaded
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			exp_range <= 1'b0;
		end else if (align) begin
			exp_range <= above_max || below_min;
		end
	end

endmodule

/* rtl/fpm_fic.sv */
module fpm_fic import fpm_pkg::*; (
	input  logic     f2strob,
	input  logic     _0_d_,
	input  logic     align,
	input  exp_ext_t sum,
	input  logic     sum_neg,
	input  logic     count,
	output logic     fic
);

	fic_t cnt;
	logic cnt_up;

	// negative distance counts up towards zero, positive counts down
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			cnt    <= '0;
			cnt_up <= 1'b0;
		end else if (align) begin
			cnt    <= sum[fic_w-1:0];
			cnt_up <= sum_neg;
		end else if (count) begin
			if (cnt_up) begin
				cnt <= cnt + fic_t'(1);
			end else begin
				cnt <= cnt - fic_t'(1);
			end
		end
	end

	// alignment done
	assign fic = (cnt == '0);

endmodule

/* rtl/fpm_flags.sv */
module fpm_flags import fpm_pkg::*; (
	input  logic        f2strob,
	input  logic        _0_d_,
	input  logic        flags_ld,
	input  op_flags_t   op_flags,
	input  t_status_t   t_status,
	input  logic        exp_range,
	output cond_flags_t flags
);

	cond_flags_t flags_next;
	logic        any_op;

	assign any_op = op_flags.is_fixed || op_flags.is_float;

	always_comb begin
		// carry only for fixed add and subtract
		flags_next.c_f = op_flags.ad_sd & t_status.carry;

		// exponent overflow counts only in floating point
		flags_next.v_f = t_status.t_ovf | (op_flags.is_float & exp_range);

		flags_next.m_f = t_status.t_sign;

		flags_next.z_f = any_op & t_status.t_zero;
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			flags <= '0;
		end else if (flags_ld) begin
			flags <= flags_next;
		end
	end

endmodule

/* rtl/fpm.sv */
module fpm import fpm_pkg::*; (
	input  logic        f2strob,
	input  logic        _0_d_,
	input  logic        start,
	input  ir_field_t   ir,
	input  logic        pufa,
	input  logic        ld,
	input  logic        lkb,
	input  exp_t        w,
	input  logic        b_ld,
	input  b_sel_t      b_sel,
	input  logic        pc8,
	input  logic        align,
	input  logic        count,
	input  logic        flags_ld,
	input  t_status_t   t_status,
	output fp_op_t      op,
	output op_flags_t   op_flags,
	output exp_t        d,
	output exp_ext_t    sum,
	output logic        sum_neg,
	output logic        exp_range,
	output logic        fic,
	output cond_flags_t flags
);

	fpm_decoder u_decoder (
		.f2strob  (f2strob),
		._0_d_    (_0_d_),
		.start    (start),
		.ir       (ir),
		.pufa     (pufa),
		.op       (op),
		.op_flags (op_flags)
	);

	fpm_exp_path u_exp_path (
		.f2strob   (f2strob),
		._0_d_     (_0_d_),
		.ld        (ld),
		.lkb       (lkb),
		.w         (w),
		.b_ld      (b_ld),
		.b_sel     (b_sel),
		.pc8       (pc8),
		.align     (align),
		.d         (d),
		.sum       (sum),
		.sum_neg   (sum_neg),
		.exp_range (exp_range)
	);

	fpm_fic u_fic (
		.f2strob (f2strob),
		._0_d_   (_0_d_),
		.align   (align),
		.sum     (sum),
		.sum_neg (sum_neg),
		.count   (count),
		.fic     (fic)
	);

	fpm_flags u_flags (
		.f2strob   (f2strob),
		._0_d_     (_0_d_),
		.flags_ld  (flags_ld),
		.op_flags  (op_flags),
		.t_status  (t_status),
		.exp_range (exp_range),
		.flags     (flags)
	);

endmodule

/* dv/fpm_tb.sv */
module fpm_tb import fpm_pkg::*; ();

	localparam int clk_period = 100;
	localparam int test_cycles = 2000;
	localparam int margin_cycles = 500;

	// one bit per strobe, start in bit 0 up to flags_ld in bit 5
	localparam logic [5:0] stb_idle = 6'd0;
	localparam logic [5:0] stb_start = 6'd1;
	localparam logic [5:0] stb_ld = 6'd2;
	localparam logic [5:0] stb_bld = 6'd4;
	localparam logic [5:0] stb_align = 6'd8;
	localparam logic [5:0] stb_count = 6'd16;
	localparam logic [5:0] stb_flags = 6'd32;

	logic f2strob, _0_d_, start, pufa, ld, lkb, b_ld, pc8, align, count, flags_ld;
	ir_field_t ir;
	exp_t w;
	b_sel_t b_sel;
	t_status_t t_status;
	fp_op_t op;
	op_flags_t op_flags;
	exp_t d;
	exp_ext_t sum;
	logic sum_neg, exp_range, fic;
	cond_flags_t flags;

	// reference state
	exp_t d_ref, b_ref;
	fp_op_t op_ref;
	fic_t cnt_ref;
	logic up_ref, range_ref;
	cond_flags_t flags_ref;
	fp_op_t op_order [8];
	int err_count;
	logic [31:0] rnd;
	int i;
	int j;

	fpm dut0 (.*);

	initial begin
		f2strob = 1'b0;
		forever #(clk_period / 2) f2strob = ~f2strob;
	end

	initial begin
		#((test_cycles + margin_cycles) * clk_period);
		$display("timeout: the test sequence did not complete in time");
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic exp_ext_t sum_model(input exp_t b, input exp_t dv,
			input b_sel_t sel, input logic c);
		exp_t bb;
		int s;
		case (sel)
			bsel_inv: bb = ~b;
			bsel_pass: bb = b;
			bsel_ones: bb = 8'hff;
			default: bb = 8'h00;
		endcase
		s = int'($signed(bb)) + int'($signed(dv)) + int'(c);
		return exp_ext_t'(s);
	endfunction

	function automatic logic out_of_range(input exp_ext_t s);
		return int'($signed(s)) > exp_max || int'($signed(s)) < exp_min;
	endfunction

	function automatic op_flags_t group_model(input fp_op_t o);
		op_flags_t g;
		g.ad_sd = o inside {op_ad, op_sd};
		g.mw_mf = o inside {op_mw, op_mf};
		g.dw_df = o inside {op_dw, op_df};
		g.af_sf = o inside {op_af, op_sf};
		g.is_float = o inside {op_af, op_sf, op_mf, op_df};
		g.is_fixed = o inside {op_ad, op_sd, op_mw, op_dw};
		return g;
	endfunction

	function automatic cond_flags_t flags_model(input fp_op_t o, input t_status_t ts,
			input logic rng);
		op_flags_t g;
		cond_flags_t f;
		g = group_model(o);
		f.c_f = g.ad_sd && ts.carry;
		f.v_f = ts.t_ovf || (g.is_float && rng);
		f.m_f = ts.t_sign;
		f.z_f = (o != op_none) && ts.t_zero;
		return f;
	endfunction

	task automatic check_val(input string name, input logic [31:0] expv,
			input logic [31:0] actv);
		assert (actv === expv)
		else begin
			$display("ERR %s expected 0x%0h actual 0x%0h", name, expv, actv);
			err_count++;
		end
	endtask

	task automatic check_all();
		exp_ext_t s;
		s = sum_model(b_ref, d_ref, b_sel, pc8);
		check_val("op", 32'(op_ref), 32'(op));
		check_val("op_flags", 32'(group_model(op_ref)), 32'(op_flags));
		check_val("d", 32'(d_ref), 32'(d));
		check_val("sum", 32'(s), 32'(sum));
		check_val("sum_neg", 32'(s[9]), 32'(sum_neg));
		check_val("exp_range", 32'(range_ref), 32'(exp_range));
		check_val("fic", 32'(cnt_ref == '0), 32'(fic));
		check_val("flags", 32'(flags_ref), 32'(flags));
	endtask

	// one-cycle strobe pulse with the reference stepped from the old state
	task automatic apply(input logic [5:0] stb);
		exp_ext_t s;
		@(posedge f2strob);
		{flags_ld, count, align, b_ld, ld, start} <= stb;
		@(posedge f2strob);
		{flags_ld, count, align, b_ld, ld, start} <= 6'd0;
		s = sum_model(b_ref, d_ref, b_sel, pc8);
		if (stb[5]) flags_ref = flags_model(op_ref, t_status, range_ref);
		if (stb[3]) begin
			range_ref = out_of_range(s);
			cnt_ref = s[5:0];
			up_ref = s[9];
		end else if (stb[4]) begin
			cnt_ref = up_ref ? cnt_ref + fic_t'(1) : cnt_ref - fic_t'(1);
		end
		if (stb[2]) b_ref = d_ref;
		if (stb[1]) d_ref = lkb ? w : s[7:0];
		if (stb[0]) op_ref = pufa ? op_order[ir] : op_none;
		@(negedge f2strob);
		check_all();
	endtask

	task automatic set_exp(input exp_t v, input logic k, input b_sel_t sel, input logic c);
		@(posedge f2strob);
		w <= v;
		lkb <= k;
		b_sel <= sel;
		pc8 <= c;
	endtask

	task automatic run_count(input exp_t dv);
		exp_ext_t s;
		int n;
		int idle;
		int k;
		set_exp(dv, 1'b1, bsel_zero, 1'b0);
		apply(stb_ld);
		s = sum_model(b_ref, d_ref, bsel_zero, 1'b0);
		n = s[9] ? (64 - int'(s[5:0])) % 64 : int'(s[5:0]);
		apply(stb_align);
		check_val("fic", 32'(n == 0), 32'(fic));
		for (k = 1; k <= n; k++) begin
			rnd = xorshift(rnd);
			idle = int'(rnd % 3);
			repeat (idle) apply(stb_idle);
			apply(stb_count);
			check_val("fic", 32'(k == n), 32'(fic));
		end
	endtask

	initial begin
		err_count = 0;
		rnd = 32'h6e682ab4;
		op_order = '{op_ad, op_sd, op_mw, op_dw, op_af, op_sf, op_mf, op_df};
		{d_ref, b_ref, cnt_ref, up_ref, range_ref} = '0;
		op_ref = op_none;
		flags_ref = '0;
		_0_d_ <= 1'b0;
		{flags_ld, count, align, b_ld, ld, start} <= 6'd0;
		{pufa, lkb, pc8} <= 3'd0;
		ir <= '0;
		w <= '0;
		b_sel <= bsel_zero;
		t_status <= '0;
		repeat (5) @(posedge f2strob);
		_0_d_ <= 1'b1;
		@(negedge f2strob);
		check_all();

		// every decoder field value and once without pufa
		for (i = 0; i < 9; i++) begin
			@(posedge f2strob);
			ir <= ir_field_t'(i % 8);
			pufa <= (i < 8);
			apply(stb_start);
		end

		// exponent path
		for (i = 0; i < 8; i++) begin
			rnd = xorshift(rnd);
			set_exp(rnd[7:0], 1'b1, bsel_pass, 1'b0);
			apply(stb_ld);
			apply(stb_bld);
			set_exp(rnd[15:8], 1'b1, bsel_pass, 1'b0);
			apply(stb_ld);
			for (j = 0; j < 4; j++) begin
				set_exp(w, 1'b0, b_sel_t'(j[1:0]), rnd[16 + j]);
				apply(stb_idle);
			end
			apply(stb_ld);
			set_exp(rnd[31:24], 1'b1, bsel_inv, 1'b1);
			apply(stb_ld | stb_bld);
		end

		// range edges at 127/128 and -128/-129
		set_exp(8'd127, 1'b1, bsel_zero, 1'b0);
		apply(stb_ld);
		apply(stb_align);
		set_exp(8'd127, 1'b1, bsel_zero, 1'b1);
		apply(stb_align);
		set_exp(8'h80, 1'b1, bsel_zero, 1'b0);
		apply(stb_ld);
		apply(stb_align);
		set_exp(8'h80, 1'b1, bsel_ones, 1'b0);
		apply(stb_align);
		set_exp(8'h80, 1'b1, bsel_ones, 1'b1);
		apply(stb_align);

		run_count(8'd13);
		run_count(8'hf7);
		rnd = xorshift(rnd);
		run_count(rnd[7:0]);

		// exponent overflow with carry set, once fixed add and once float add
		set_exp(8'd127, 1'b1, bsel_zero, 1'b1);
		apply(stb_ld);
		apply(stb_align);
		for (i = 0; i < 2; i++) begin
			@(posedge f2strob);
			ir <= ir_field_t'(i * 4);
			pufa <= 1'b1;
			t_status <= 4'b0001;
			apply(stb_start);
			apply(stb_flags);
		end

		// flags with random operations and status
		for (i = 0; i < 24; i++) begin
			rnd = xorshift(rnd);
			@(posedge f2strob);
			ir <= rnd[2:0];
			pufa <= rnd[3] | rnd[4];
			apply(stb_start);
			set_exp(rnd[15:8], 1'b1, b_sel_t'(rnd[17:16]), rnd[18]);
			apply(stb_ld);
			apply(stb_align);
			@(posedge f2strob);
			t_status <= rnd[23:20];
			apply(stb_flags);
		end

		$display("errors: %0d", err_count);
		if (err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
common/fpm_pkg.sv
rtl/fpm_decoder.sv
exponent/fpm_exp_path.sv
rtl/fpm_fic.sv
rtl/fpm_flags.sv
rtl/fpm.sv
dv/fpm_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fpm_tb -f src.f -o fpm_sim

./obj_dir/fpm_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
